//--- project.f
src/cpu_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_pipeline.sv
testbench/tb_cpu_pipeline.sv

//--- testbench/tb_cpu_pipeline.sv
module tb_cpu_pipeline
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t MARKER_ADDR     = 32'h0000_0ffc;
    localparam data_t MARKER_VALUE    = 32'h0000_0ace;
    localparam addr_t WRONG_PATH_ADDR = 32'h0000_0f00;
    localparam int    TIMEOUT_CYCLES  = 500;

    logic  clk;
    logic  reset;
    addr_t imem_addr;
    data_t imem_data;
    logic  dmem_read;
    logic  dmem_write;
    addr_t dmem_addr;
    data_t dmem_wdata;
    data_t dmem_rdata;
    addr_t mem_pc;

    data_t imem [1024];
    data_t dmem [1024];
    int    prog_len;
    logic  marker_seen;

    // Stores seen on the data port in program order
    addr_t wr_addr_q [$];
    data_t wr_data_q [$];
    addr_t exp_addr_q [$];
    data_t exp_data_q [$];
    // Load addresses seen on the data port
    addr_t rd_addr_q [$];

    logic [15:0] lfsr_state;
    int error_count;
    int tests_run;
    int tests_failed;

    cpu_pipeline dut0 (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .imem_addr  ( imem_addr  ),
        .imem_data  ( imem_data  ),
        .dmem_read  ( dmem_read  ),
        .dmem_write ( dmem_write ),
        .dmem_addr  ( dmem_addr  ),
        .dmem_wdata ( dmem_wdata ),
        .dmem_rdata ( dmem_rdata ),
        .mem_pc     ( mem_pc     )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_read) begin
            rd_addr_q.push_back(dmem_addr);
        end
        if (dmem_write) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
            wr_addr_q.push_back(dmem_addr);
            wr_data_q.push_back(dmem_wdata);
            if (dmem_addr == MARKER_ADDR) begin
                marker_seen <= 1'b1;
            end
        end
    end

    function automatic data_t fill_word(int byte_addr);
        return 32'hda7a_0000 | data_t'(byte_addr);
    endfunction

    task automatic clear_memories();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i * 4);
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        rd_addr_q.delete();
        marker_seen = 1'b0;
        prog_len = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic data_t rtype_word(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                         reg_addr_t rd, logic [4:0] shamt);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic data_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target is a word index and the upper PC bits stay zero
    function automatic data_t jump_word(logic [5:0] op, int index);
        return {op, 26'(index)};
    endfunction

    task automatic emit(data_t word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_write(addr_t addr, data_t value);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(value);
    endtask

    // Marker store and then a jump to itself
    task automatic end_program();
        emit(itype_word(OP_ADDIU, 0, 30, MARKER_VALUE[15:0]));
        emit(itype_word(OP_SW, 0, 30, MARKER_ADDR[15:0]));
        emit(jump_word(OP_J, prog_len));
        expect_write(MARKER_ADDR, MARKER_VALUE);
    endtask

    task automatic wrong_path(int count);
        for (int i = 0; i < count; i++) begin
            emit(itype_word(OP_SW, 0, 1, WRONG_PATH_ADDR[15:0]));
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic data_t random_word();
        data_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(string what, data_t got, data_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic start_program();
        @(negedge clk);
        reset = 1'b1;
        clear_memories();
    endtask

    task automatic hold_reset();
        repeat (10) @(negedge clk);
    endtask

    task automatic run_program(string name, output bit seen);
        int cycles;
        cycles = 0;
        hold_reset();
        reset = 1'b0;
        while (!marker_seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        seen = marker_seen;
        if (!seen) begin
            $display("Timeout: %s ran %0d cycles without storing its end marker",
                     name, TIMEOUT_CYCLES);
            error_count++;
        end
    endtask

    task automatic compare_writes();
        if (wr_addr_q.size() != exp_addr_q.size()) begin
            $display("Wrong number of stores: %0d seen, %0d expected",
                     wr_addr_q.size(), exp_addr_q.size());
            error_count++;
        end
        for (int i = 0; i < exp_addr_q.size() && i < wr_addr_q.size(); i++) begin
            check_addr($sformatf("store %0d address", i), wr_addr_q[i], exp_addr_q[i]);
            check_data($sformatf("store %0d data", i), wr_data_q[i], exp_data_q[i]);
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state_test();
        int errors_before;
        errors_before = error_count;
        start_program();
        hold_reset();
        check_data("dmem_read in reset", data_t'(dmem_read), '0);
        check_data("dmem_write in reset", data_t'(dmem_write), '0);
        check_addr("mem_pc in reset", mem_pc, RESET_PC);
        reset = 1'b0;
        // Nops only, so fetch just walks forward
        for (int k = 0; k < 8; k++) begin
            check_addr($sformatf("fetch address %0d", k), imem_addr, RESET_PC + addr_t'(4 * k));
            check_data("dmem_read idle", data_t'(dmem_read), '0);
            check_data("dmem_write idle", data_t'(dmem_write), '0);
            if (k >= 3) begin
                // The fetch of three cycles back is now in MEM
                check_addr($sformatf("mem_pc %0d", k), mem_pc,
                           RESET_PC + addr_t'(4 * (k - 3)));
            end
            @(negedge clk);
        end
        finish_test("reset_state", errors_before);
    endtask

    task automatic alu_chain_test();
        int    errors_before;
        data_t e [19];
        bit    seen;
        errors_before = error_count;
        start_program();
        emit(itype_word(OP_ADDIU, 0, 1, 16'h1234));
        e[0] = 32'h0000_1234;
        emit(itype_word(OP_ADDIU, 1, 2, 16'hfffb));
        e[1] = e[0] - 32'd5;
        emit(rtype_word(FN_ADDU, 1, 2, 3, 5'd0));
        e[2] = e[0] + e[1];
        emit(rtype_word(FN_SLL, 0, 3, 4, 5'd4));
        e[3] = e[2] << 4;
        emit(itype_word(OP_LUI, 0, 5, 16'h8000));
        e[4] = 32'h8000_0000;
        emit(rtype_word(FN_SRA, 0, 5, 6, 5'd3));
        e[5] = 32'hf000_0000;
        emit(rtype_word(FN_SRL, 0, 5, 7, 5'd3));
        e[6] = 32'h1000_0000;
        emit(rtype_word(FN_SUBU, 7, 4, 8, 5'd0));
        e[7] = e[6] - e[3];
        emit(rtype_word(FN_SLT, 6, 7, 9, 5'd0));
        e[8] = ($signed(e[5]) < $signed(e[6])) ? 32'd1 : 32'd0;
        emit(rtype_word(FN_SLTU, 6, 7, 10, 5'd0));
        e[9] = (e[5] < e[6]) ? 32'd1 : 32'd0;
        emit(itype_word(OP_XORI, 8, 11, 16'hffff));
        e[10] = e[7] ^ 32'h0000_ffff;
        emit(rtype_word(FN_NOR, 11, 3, 12, 5'd0));
        e[11] = ~(e[10] | e[2]);
        emit(itype_word(OP_ANDI, 12, 13, 16'h0f0f));
        e[12] = e[11] & 32'h0000_0f0f;
        emit(rtype_word(FN_SLLV, 1, 13, 14, 5'd0));
        e[13] = e[12] << e[0][4:0];
        emit(itype_word(OP_SLTI, 6, 15, 16'hffff));
        e[14] = ($signed(e[5]) < $signed(32'hffff_ffff)) ? 32'd1 : 32'd0;
        emit(itype_word(OP_ORI, 14, 16, 16'h00f0));
        e[15] = e[13] | 32'h0000_00f0;
        emit(rtype_word(FN_AND, 16, 2, 17, 5'd0));
        e[16] = e[15] & e[1];
        emit(rtype_word(FN_OR, 17, 3, 18, 5'd0));
        e[17] = e[16] | e[2];
        emit(rtype_word(FN_SRLV, 9, 6, 19, 5'd0));
        e[18] = e[5] >> e[8][4:0];
        for (int i = 0; i < 19; i++) begin
            emit(itype_word(OP_SW, 0, reg_addr_t'(i + 1), 16'(32'h100 + 4 * i)));
            expect_write(addr_t'(32'h100 + 4 * i), e[i]);
        end
        end_program();
        run_program("alu_chain", seen);
        if (seen) begin
            compare_writes();
        end
        finish_test("alu_chain", errors_before);
    endtask

    task automatic load_use_test();
        int  errors_before;
        bit  seen;
        errors_before = error_count;
        start_program();
        emit(itype_word(OP_ADDIU, 0, 1, 16'h0077));
        emit(itype_word(OP_LUI, 0, 2, 16'h1357));
        emit(itype_word(OP_ORI, 2, 2, 16'h2468));
        emit(itype_word(OP_SW, 0, 2, 16'h0200));
        emit(itype_word(OP_LW, 0, 3, 16'h0200));
        emit(rtype_word(FN_ADDU, 3, 1, 4, 5'd0));
        emit(itype_word(OP_SW, 0, 4, 16'h0204));
        // Load straight into a store
        emit(itype_word(OP_LW, 0, 5, 16'h0204));
        emit(itype_word(OP_SW, 0, 5, 16'h0208));
        emit(itype_word(OP_LW, 0, 6, 16'h0300));
        emit(itype_word(OP_ADDIU, 6, 7, 16'h0001));
        emit(itype_word(OP_SW, 0, 7, 16'h020c));
        expect_write(32'h200, 32'h1357_2468);
        expect_write(32'h204, 32'h1357_2468 + 32'h77);
        expect_write(32'h208, 32'h1357_2468 + 32'h77);
        expect_write(32'h20c, fill_word(32'h300) + 32'd1);
        end_program();
        run_program("load_use", seen);
        if (seen) begin
            compare_writes();
            if (rd_addr_q.size() != 3) begin
                $display("Wrong number of loads: %0d seen, 3 expected", rd_addr_q.size());
                error_count++;
            end else begin
                check_addr("load 0 address", rd_addr_q[0], 32'h200);
                check_addr("load 1 address", rd_addr_q[1], 32'h204);
                check_addr("load 2 address", rd_addr_q[2], 32'h300);
            end
        end
        finish_test("load_use", errors_before);
    endtask

    task automatic control_flow_test();
        int errors_before;
        int jal_index;
        int jr_index;
        bit seen;
        errors_before = error_count;
        start_program();
        emit(itype_word(OP_ADDIU, 0, 1, 16'd5));
        emit(itype_word(OP_ADDIU, 0, 2, 16'd5));
        emit(itype_word(OP_ADDIU, 0, 3, 16'd7));
        emit(itype_word(OP_BEQ, 1, 2, 16'd3));
        wrong_path(3);
        // A wrong take of this bne lands on squashed stores
        emit(itype_word(OP_BNE, 1, 2, 16'd5));
        emit(itype_word(OP_ADDIU, 0, 4, 16'h0011));
        emit(itype_word(OP_SW, 0, 4, 16'h0500));
        emit(itype_word(OP_BEQ, 1, 3, 16'd3));
        emit(itype_word(OP_ADDIU, 4, 4, 16'h0001));
        emit(itype_word(OP_BNE, 1, 3, 16'd3));
        wrong_path(3);
        emit(itype_word(OP_SW, 0, 4, 16'h0504));
        emit(jump_word(OP_J, prog_len + 3));
        wrong_path(2);
        jal_index = prog_len;
        emit(jump_word(OP_JAL, prog_len + 4));
        wrong_path(3);
        emit(itype_word(OP_SW, 0, 31, 16'h0508));
        jr_index = prog_len + 5;
        emit(itype_word(OP_ADDIU, 0, 5, 16'(jr_index * 4)));
        emit(rtype_word(FN_JR, 5, 0, 0, 5'd0));
        wrong_path(3);
        emit(itype_word(OP_SW, 0, 5, 16'h050c));
        expect_write(32'h500, 32'h11);
        expect_write(32'h504, 32'h12);
        expect_write(32'h508, data_t'(jal_index * 4 + 4));
        expect_write(32'h50c, data_t'(jr_index * 4));
        end_program();
        run_program("control_flow", seen);
        if (seen) begin
            compare_writes();
        end
        foreach (wr_addr_q[i]) begin
            if (wr_addr_q[i] == WRONG_PATH_ADDR) begin
                $display("A store from a squashed path reached memory as store %0d", i);
                error_count++;
            end
        end
        finish_test("control_flow", errors_before);
    endtask

    task automatic random_alu_test();
        int    errors_before;
        data_t a;
        data_t b;
        addr_t base;
        bit    seen;
        errors_before = error_count;
        start_program();
        for (int k = 0; k < 20; k++) begin
            a = random_word();
            b = random_word();
            base = 32'h600 + addr_t'(20 * k);
            emit(itype_word(OP_LUI, 0, 1, a[31:16]));
            emit(itype_word(OP_ORI, 1, 1, a[15:0]));
            emit(itype_word(OP_LUI, 0, 2, b[31:16]));
            emit(itype_word(OP_ORI, 2, 2, b[15:0]));
            emit(rtype_word(FN_ADDU, 1, 2, 3, 5'd0));
            emit(rtype_word(FN_SUBU, 1, 2, 4, 5'd0));
            emit(rtype_word(FN_XOR, 1, 2, 5, 5'd0));
            emit(rtype_word(FN_SLTU, 1, 2, 6, 5'd0));
            emit(rtype_word(FN_SRAV, 1, 2, 7, 5'd0));
            for (int j = 0; j < 5; j++) begin
                emit(itype_word(OP_SW, 0, reg_addr_t'(3 + j), base[15:0] + 16'(4 * j)));
            end
            expect_write(base, a + b);
            expect_write(base + 32'd4, a - b);
            expect_write(base + 32'd8, a ^ b);
            expect_write(base + 32'd12, (a < b) ? 32'd1 : 32'd0);
            expect_write(base + 32'd16, data_t'($signed(b) >>> a[4:0]));
        end
        end_program();
        run_program("random_alu", seen);
        if (seen) begin
            compare_writes();
        end
        finish_test("random_alu", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        lfsr_state = 16'd51;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        clear_memories();

        reset_state_test();
        alu_chain_test();
        load_use_test();
        control_flow_test();
        random_alu_test();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/cpu_pipeline.sv
module cpu_pipeline
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output addr_t imem_addr,
    input  data_t imem_data,
    output logic  dmem_read,
    output logic  dmem_write,
    output addr_t dmem_addr,
    output data_t dmem_wdata,
    input  data_t dmem_rdata,
    output addr_t mem_pc
);

    ifid_t  ifid;
    idex_t  idex;
    exmem_t exmem;
    memwb_t memwb;

    logic  load_use_stall;
    logic  id_redirect;
    addr_t id_target;
    // A taken branch or jr in MEM also flushes ID and EX
    logic  mem_redirect;
    addr_t mem_target;

    fetch_stage fetch0 (
        .clk          ( clk            ),
        .reset        ( reset          ),
        .stall        ( load_use_stall ),
        .mem_redirect ( mem_redirect   ),
        .mem_target   ( mem_target     ),
        .id_redirect  ( id_redirect    ),
        .id_target    ( id_target      ),
        .imem_addr    ( imem_addr      ),
        .imem_data    ( imem_data      ),
        .ifid         ( ifid           )
    );

    decode_stage decode0 (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .ifid           ( ifid           ),
        .flush          ( mem_redirect   ),
        .memwb          ( memwb          ),
        .idex           ( idex           ),
        .load_use_stall ( load_use_stall ),
        .id_redirect    ( id_redirect    ),
        .id_target      ( id_target      )
    );

    execute_stage execute0 (
        .clk     ( clk          ),
        .reset   ( reset        ),
        .idex    ( idex         ),
        .flush   ( mem_redirect ),
        .mem_fwd ( exmem        ),
        .wb_fwd  ( memwb        ),
        .exmem   ( exmem        )
    );

    memory_stage memory0 (
        .clk        ( clk          ),
        .reset      ( reset        ),
        .exmem      ( exmem        ),
        .dmem_read  ( dmem_read    ),
        .dmem_write ( dmem_write   ),
        .dmem_addr  ( dmem_addr    ),
        .dmem_wdata ( dmem_wdata   ),
        .dmem_rdata ( dmem_rdata   ),
        .redirect   ( mem_redirect ),
        .target     ( mem_target   ),
        .memwb      ( memwb        )
    );

    assign mem_pc = exmem.pc;

endmodule

//--- src/memory_stage.sv
module memory_stage
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  exmem_t exmem,
    output logic   dmem_read,
    output logic   dmem_write,
    output addr_t  dmem_addr,
    output data_t  dmem_wdata,
    input  data_t  dmem_rdata,
    output logic   redirect,
    output addr_t  target,
    output memwb_t memwb
);

    logic taken;

    always_comb begin
        case (exmem.branch_cond)
        BR_EQ:   taken = exmem.zero;
        BR_NE:   taken = !exmem.zero;
        BR_JR:   taken = 1'b1;
        default: taken = 1'b0;
        endcase
    end

    assign redirect = exmem.valid && taken;
    assign target = (exmem.branch_cond == BR_JR) ? exmem.result : exmem.branch_target;

    assign dmem_read  = exmem.valid && exmem.mem_read;
    assign dmem_write = exmem.valid && exmem.mem_write;
    assign dmem_addr  = exmem.result;
    assign dmem_wdata = exmem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            memwb <= '0;
        end else begin
            memwb.reg_write <= exmem.valid && exmem.reg_write;
            memwb.dest      <= exmem.dest;
            memwb.data      <= exmem.mem_read ? dmem_rdata : exmem.result;
        end
    end

endmodule

//--- src/execute_stage.sv
module execute_stage
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  idex_t  idex,
    input  logic   flush,
    input  exmem_t mem_fwd,
    input  memwb_t wb_fwd,
    output exmem_t exmem
);

    data_t      op_a;
    data_t      op_b;
    data_t      alu_b;
    data_t      alu_result;
    data_t      ex_result;
    logic [4:0] alu_shamt;
    logic       alu_less;
    logic       alu_zero;

    // Youngest producer first; a load in MEM is covered by the stall
    function automatic data_t forward(reg_addr_t idx, data_t value);
        if (mem_fwd.valid && mem_fwd.reg_write && !mem_fwd.mem_read && mem_fwd.dest == idx) begin
            return mem_fwd.result;
        end
        if (wb_fwd.reg_write && wb_fwd.dest == idx) begin
            return wb_fwd.data;
        end
        return value;
    endfunction

    always_comb begin
        op_a = forward(idex.rs, idex.rs_data);
        op_b = forward(idex.rt, idex.rt_data);
    end

    assign alu_b = idex.b_sel_imm ? idex.imm : op_b;
    assign alu_shamt = idex.shamt_from_reg ? op_a[4:0] : idex.shamt;

    alu alu0 (
        .a      ( op_a       ),
        .b      ( alu_b      ),
        .shamt  ( alu_shamt  ),
        .op     ( idex.alu_op ),
        .result ( alu_result ),
        .less   ( alu_less   ),
        .zero   ( alu_zero   )
    );

    always_comb begin
        case (idex.res_sel)
        RES_LINK: ex_result = idex.pc_plus4;
        RES_OPA:  ex_result = op_a;
        default:  ex_result = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exmem <= '0;
        end else begin
            exmem.valid         <= idex.valid;
            exmem.pc            <= idex.pc;
            exmem.pc_plus4      <= idex.pc_plus4;
            exmem.result        <= ex_result;
            exmem.store_data    <= op_b;
            exmem.dest          <= idex.dest;
            exmem.reg_write     <= idex.reg_write;
            exmem.mem_read      <= idex.mem_read;
            exmem.mem_write     <= idex.mem_write;
            exmem.branch_cond   <= idex.branch_cond;
            exmem.branch_target <= idex.pc_plus4 + (idex.imm << 2);
            exmem.less          <= alu_less;
            exmem.zero          <= alu_zero;
        end
    end

endmodule

//--- src/alu.sv
module alu
    import cpu_pkg::*;
(
    input  data_t      a,
    input  data_t      b,
    input  logic [4:0] shamt,
    input  alu_op_e    op,
    output data_t      result,
    output logic       less,
    output logic       zero
);

    always_comb begin
        if (op == ALU_SLTU) begin
            less = a < b;
        end else begin
            less = $signed(a) < $signed(b);
        end
    end

    always_comb begin
        case (op)
        ALU_ADD:  result = a + b;
        ALU_SUB:  result = a - b;
        ALU_AND:  result = a & b;
        ALU_OR:   result = a | b;
        ALU_XOR:  result = a ^ b;
        ALU_NOR:  result = ~(a | b);
        ALU_SLT,
        ALU_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, less};
        ALU_LUI:  result = {b[15:0], 16'h0};
        // Shifts act on operand B, the rt value
        ALU_SLL:  result = b << shamt;
        ALU_SRL:  result = b >> shamt;
        ALU_SRA:  result = data_t'($signed(b) >>> shamt);
        default:  result = '0;
        endcase
    end

    // With ALU_SUB this flags rs == rt for beq and bne
    assign zero = (result == '0);

endmodule

//--- src/decode_stage.sv
module decode_stage
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  ifid_t  ifid,
    input  logic   flush,
    input  memwb_t memwb,
    output idex_t  idex,
    output logic   load_use_stall,
    output logic   id_redirect,
    output addr_t  id_target
);

    data_t      instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    data_t      rs_data;
    data_t      rt_data;
    idex_t      dec;
    reg_addr_t  dest;
    logic       write_en;
    logic       sign_ext;
    logic       jump;

    assign instr  = ifid.instr;
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    register_file regfile0 (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .rs_addr ( rs      ),
        .rt_addr ( rt      ),
        .rs_data ( rs_data ),
        .rt_data ( rt_data ),
        .wb      ( memwb   )
    );

    //////////////////////////////////////////////////////////////////////
    // Decoder
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec = '0;
        dec.valid    = 1'b1;
        dec.pc       = ifid.pc;
        dec.pc_plus4 = ifid.pc_plus4;
        dec.rs       = rs;
        dec.rt       = rt;
        dec.rs_data  = rs_data;
        dec.rt_data  = rt_data;
        dec.shamt    = instr[10:6];
        dec.alu_op   = ALU_ADD;
        dest     = rt;
        write_en = 1'b0;
        sign_ext = 1'b1;
        jump     = 1'b0;

        case (opcode)
        OP_SPECIAL: begin
            dest     = rd;
            write_en = 1'b1;
            case (funct)
            FN_SLL:  dec.alu_op = ALU_SLL;
            FN_SRL:  dec.alu_op = ALU_SRL;
            FN_SRA:  dec.alu_op = ALU_SRA;
            FN_SLLV: begin
                dec.alu_op         = ALU_SLL;
                dec.shamt_from_reg = 1'b1;
            end
            FN_SRLV: begin
                dec.alu_op         = ALU_SRL;
                dec.shamt_from_reg = 1'b1;
            end
            FN_SRAV: begin
                dec.alu_op         = ALU_SRA;
                dec.shamt_from_reg = 1'b1;
            end
            FN_JR: begin
                write_en        = 1'b0;
                dec.res_sel     = RES_OPA;
                dec.branch_cond = BR_JR;
            end
            FN_ADDU: dec.alu_op = ALU_ADD;
            FN_SUBU: dec.alu_op = ALU_SUB;
            FN_AND:  dec.alu_op = ALU_AND;
            FN_OR:   dec.alu_op = ALU_OR;
            FN_XOR:  dec.alu_op = ALU_XOR;
            FN_NOR:  dec.alu_op = ALU_NOR;
            FN_SLT:  dec.alu_op = ALU_SLT;
            FN_SLTU: dec.alu_op = ALU_SLTU;
            default: write_en = 1'b0;
            endcase
        end
        OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            write_en      = 1'b1;
            dec.b_sel_imm = 1'b1;
            // Logic ops and lui take a zero-extended immediate
            sign_ext = (opcode == OP_ADDIU) || (opcode == OP_SLTI);
            case (opcode)
            OP_SLTI: dec.alu_op = ALU_SLT;
            OP_ANDI: dec.alu_op = ALU_AND;
            OP_ORI:  dec.alu_op = ALU_OR;
            OP_XORI: dec.alu_op = ALU_XOR;
            OP_LUI:  dec.alu_op = ALU_LUI;
            default: dec.alu_op = ALU_ADD;
            endcase
        end
        OP_LW: begin
            write_en      = 1'b1;
            dec.b_sel_imm = 1'b1;
            dec.mem_read  = 1'b1;
        end
        OP_SW: begin
            dec.b_sel_imm = 1'b1;
            dec.mem_write = 1'b1;
        end
        OP_BEQ: begin
            dec.alu_op      = ALU_SUB;
            dec.branch_cond = BR_EQ;
        end
        OP_BNE: begin
            dec.alu_op      = ALU_SUB;
            dec.branch_cond = BR_NE;
        end
        OP_J: jump = 1'b1;
        OP_JAL: begin
            jump        = 1'b1;
            write_en    = 1'b1;
            dest        = LINK_REG;
            dec.res_sel = RES_LINK;
        end
        default: ;
        endcase

        dec.imm = sign_ext ? {{16{instr[15]}}, instr[15:0]} : {16'h0, instr[15:0]};
        dec.dest = dest;
        // Writes to $0 are dropped here so later stages never see them
        dec.reg_write = write_en && (dest != '0);
    end

    assign id_redirect = ifid.valid && jump;
    assign id_target = {ifid.pc_plus4[31:28], instr[25:0], 2'b00};

    // Load in EX whose result the instruction in ID needs
    assign load_use_stall = ifid.valid && idex.valid && idex.mem_read && idex.reg_write &&
                            (idex.dest == rs || idex.dest == rt);

    always_ff @(posedge clk) begin
        if (reset || flush || load_use_stall || !ifid.valid) begin
            idex <= '0;
        end else begin
            idex <= dec;
        end
    end

endmodule

//--- src/register_file.sv
module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output data_t     rs_data,
    output data_t     rt_data,
    input  memwb_t    wb
);

    data_t regs [32];

    // Same-cycle write shows through to the reader
    function automatic data_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.dest == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

//--- src/fetch_stage.sv
module fetch_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  mem_redirect,
    input  addr_t mem_target,
    input  logic  id_redirect,
    input  addr_t id_target,
    output addr_t imem_addr,
    input  data_t imem_data,
    output ifid_t ifid
);

    addr_t pc;
    addr_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;
    assign imem_addr = pc;

    // Branch from MEM wins, then the stall, then a jump from ID
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (mem_redirect) begin
            pc <= mem_target;
        end else if (!stall) begin
            pc <= id_redirect ? id_target : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || mem_redirect) begin
            ifid <= '0;
        end else if (!stall) begin
            if (id_redirect) begin
                ifid <= '0;
            end else begin
                ifid <= '{valid: 1'b1, pc: pc, pc_plus4: pc_plus4, instr: imem_data};
            end
        end
    end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_WIDTH-1:0] addr_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    localparam addr_t RESET_PC = '0;
    localparam reg_addr_t LINK_REG = 5'd31;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////////////////////////

    // Primary opcode, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // Function field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // BR_JR marks jr, which redirects to the EX result
    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JR} branch_cond_e;

    typedef enum logic [1:0] {RES_ALU, RES_LINK, RES_OPA} res_sel_e;

    //////////////////////////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t pc_plus4;
        data_t instr;
    } ifid_t;

    typedef struct packed {
        logic         valid;
        addr_t        pc;
        addr_t        pc_plus4;
        data_t        rs_data;
        data_t        rt_data;
        reg_addr_t    rs;
        reg_addr_t    rt;
        data_t        imm;
        logic [4:0]   shamt;
        reg_addr_t    dest;
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        branch_cond_e branch_cond;
        alu_op_e      alu_op;
        logic         b_sel_imm;
        logic         shamt_from_reg;
        res_sel_e     res_sel;
    } idex_t;

    typedef struct packed {
        logic         valid;
        addr_t        pc;
        addr_t        pc_plus4;
        data_t        result;
        data_t        store_data;
        reg_addr_t    dest;
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        branch_cond_e branch_cond;
        addr_t        branch_target;
        logic         less;
        logic         zero;
    } exmem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        data_t     data;
    } memwb_t;

endpackage
